//--- common/xif_consts.svh
// Widths, opcode and function codes for the extension interface subsystem
// Custom-0 major opcode only; R-type codes need funct7 of zero
`ifndef XIF_CONSTS_SVH
`define XIF_CONSTS_SVH

// Operand and id widths
`define XIF_XLEN 32
`define XIF_ID_W 4

// Register index width, fixed by the RISC-V encoding
`define XIF_REG_W 5

// Major opcode of the custom-0 space
`define XIF_OPC_CUSTOM0 7'b0001011

// R-type function codes
`define XIF_F3_ABSDIFF 3'd0
`define XIF_F3_MINU 3'd1
`define XIF_F3_MAXU 3'd2
`define XIF_F3_SATADD 3'd3

// I-type function codes
`define XIF_F3_RORI 3'd4
`define XIF_F3_SATADDI 3'd5

// Instructions held between issue and commit
`define XIF_EXE_SLOTS 2

`endif

//--- common/xif_pkg.sv
// Types for both protocol versions and the coprocessor datapath
// The third source operand and extension context fields exist only on the newer side
`include "xif_consts.svh"

package xif_pkg;

  // Older, core-side protocol
  typedef struct packed {
    logic [`XIF_ID_W-1:0]          id;
    logic [31:0]                   instr;
    logic [1:0][`XIF_XLEN-1:0]     rs;
    logic [1:0]                    rs_valid;
  } core_issue_req_t;

  typedef struct packed {
    logic       accept;
    logic       writeback;
    logic [1:0] register_read;
  } core_issue_resp_t;

  typedef struct packed {
    logic [`XIF_ID_W-1:0] id;
    logic                 commit_kill;
  } core_commit_t;

  typedef struct packed {
    logic [`XIF_ID_W-1:0]  id;
    logic [`XIF_XLEN-1:0]  data;
    logic [`XIF_REG_W-1:0] rd;
    logic                  we;
  } core_result_t;

  // Newer, coprocessor-side protocol
  typedef struct packed {
    logic [1:0]                mode;
    logic [`XIF_ID_W-1:0]      id;
    logic [31:0]               instr;
    logic [2:0][`XIF_XLEN-1:0] rs;
    logic [2:0]                rs_valid;
    logic [5:0]                ecs;
    logic                      ecs_valid;
  } x_issue_req_t;

  typedef struct packed {
    logic       accept;
    logic       writeback;
    logic       dualwrite;
    logic [2:0] dualread;
    logic       loadstore;
    logic       ecswrite;
    logic       exc;
  } x_issue_resp_t;

  typedef struct packed {
    logic [`XIF_ID_W-1:0] id;
    logic                 commit_kill;
  } x_commit_t;

  typedef struct packed {
    logic [`XIF_ID_W-1:0]  id;
    logic [`XIF_XLEN-1:0]  data;
    logic [`XIF_REG_W-1:0] rd;
    logic                  we;
  } x_result_t;

  // Instruction word views
  typedef struct packed {
    logic [6:0]            funct7;
    logic [`XIF_REG_W-1:0] rs2;
    logic [`XIF_REG_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [`XIF_REG_W-1:0] rd;
    logic [6:0]            opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]           imm12;
    logic [`XIF_REG_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [`XIF_REG_W-1:0] rd;
    logic [6:0]            opcode;
  } i_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } instr_u;

  typedef enum logic [2:0] {
    OP_ABSDIFF,
    OP_MINU,
    OP_MAXU,
    OP_SATADD,
    OP_RORI,
    OP_SATADDI
  } copro_op_e;

  typedef struct packed {
    logic [`XIF_ID_W-1:0]  id;
    copro_op_e             op;
    logic [`XIF_XLEN-1:0]  rs1;
    logic [`XIF_XLEN-1:0]  rs2;
    logic [11:0]           imm12;
    logic [`XIF_REG_W-1:0] rd;
    logic                  writeback;
  } copro_uop_t;

endpackage

//--- logic/xif_adapter.sv
// Bridges the older issue/commit/result protocol to the newer one
// Assumes the core commits every issued id once and never reuses an id in flight
`include "xif_consts.svh"

module xif_adapter (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      core_issue_valid_i,
  output logic                      core_issue_ready_o,
  input  xif_pkg::core_issue_req_t  core_issue_req_i,
  output xif_pkg::core_issue_resp_t core_issue_resp_o,
  input  logic                      core_commit_valid_i,
  input  xif_pkg::core_commit_t     core_commit_i,
  output logic                      core_result_valid_o,
  input  logic                      core_result_ready_i,
  output xif_pkg::core_result_t     core_result_o,
  output logic                      x_issue_valid_o,
  input  logic                      x_issue_ready_i,
  output xif_pkg::x_issue_req_t     x_issue_req_o,
  input  xif_pkg::x_issue_resp_t    x_issue_resp_i,
  output logic                      x_commit_valid_o,
  output xif_pkg::x_commit_t        x_commit_o,
  input  logic                      x_result_valid_i,
  output logic                      x_result_ready_o,
  input  xif_pkg::x_result_t        x_result_i
);
  import xif_pkg::*;

  localparam int IDS = 2 ** `XIF_ID_W;

  // Issued but not yet committed, and accepted but not yet completed
  logic [IDS-1:0] issued_q;
  logic [IDS-1:0] outst_q;

  // Issue path
  assign x_issue_valid_o         = core_issue_valid_i;
  assign core_issue_ready_o      = x_issue_ready_i;
  assign x_issue_req_o.mode      = '0;
  assign x_issue_req_o.id        = core_issue_req_i.id;
  assign x_issue_req_o.instr     = core_issue_req_i.instr;
  assign x_issue_req_o.rs        = {{`XIF_XLEN{1'b0}}, core_issue_req_i.rs};
  assign x_issue_req_o.rs_valid  = {1'b0, core_issue_req_i.rs_valid};
  assign x_issue_req_o.ecs       = '0;
  assign x_issue_req_o.ecs_valid = 1'b0;

  assign core_issue_resp_o.accept        = x_issue_resp_i.accept;
  assign core_issue_resp_o.writeback     = x_issue_resp_i.writeback;
  // No instructions in flight on the core, so both registers are always read
  assign core_issue_resp_o.register_read = 2'b11;

  // Commits for rejected instructions never reach the coprocessor
  assign x_commit_valid_o = core_commit_valid_i && outst_q[core_commit_i.id];
  assign x_commit_o.id          = core_commit_i.id;
  assign x_commit_o.commit_kill = core_commit_i.commit_kill;

  // Result path
  assign core_result_valid_o = x_result_valid_i;
  assign x_result_ready_o    = core_result_ready_i;
  assign core_result_o.id    = x_result_i.id;
  assign core_result_o.data  = x_result_i.data;
  assign core_result_o.rd    = x_result_i.rd;
  assign core_result_o.we    = x_result_i.we;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      issued_q <= '0;
      outst_q  <= '0;
    end else begin
      if (core_issue_valid_i && core_issue_ready_o) begin
        issued_q[core_issue_req_i.id] <= 1'b1;
        outst_q[core_issue_req_i.id]  <= x_issue_resp_i.accept;
      end
      if (core_commit_valid_i) begin
        issued_q[core_commit_i.id] <= 1'b0;
        if (core_commit_i.commit_kill) begin
          outst_q[core_commit_i.id] <= 1'b0;
        end
      end
      if (x_result_valid_i && x_result_ready_o) begin
        outst_q[x_result_i.id] <= 1'b0;
      end
    end
  end

  a_result_outstanding: assert property (@(posedge clk_i) disable iff (rst_i)
    x_result_valid_i |-> outst_q[x_result_i.id]);

  a_commit_issued: assert property (@(posedge clk_i) disable iff (rst_i)
    core_commit_valid_i |-> issued_q[core_commit_i.id]);

  a_resp_unsupported: assert property (@(posedge clk_i) disable iff (rst_i)
    x_issue_valid_o |->
      !(x_issue_resp_i.exc || x_issue_resp_i.dualwrite || x_issue_resp_i.loadstore));

endmodule

//--- coproc/coproc_decode.sv
// Combinational decode of an offered custom-0 instruction
// R-type needs funct7 zero and both operands valid; I-type needs rs1 only
`include "xif_consts.svh"

module coproc_decode (
  input  logic                   x_issue_valid_i,
  input  xif_pkg::x_issue_req_t  x_issue_req_i,
  output xif_pkg::x_issue_resp_t x_issue_resp_o,
  output xif_pkg::copro_uop_t    uop_o,
  output logic                   uop_accept_o
);
  import xif_pkg::*;

  instr_u    ins;
  copro_op_e op;
  logic      known;
  logic      is_r;
  logic      opnd_ok;
  logic      accept;
  logic      wb;

  assign ins = x_issue_req_i.instr;

  always_comb begin
    op    = OP_ABSDIFF;
    known = 1'b1;
    is_r  = 1'b1;
    case (ins.r.funct3)
      `XIF_F3_ABSDIFF: op = OP_ABSDIFF;
      `XIF_F3_MINU:    op = OP_MINU;
      `XIF_F3_MAXU:    op = OP_MAXU;
      `XIF_F3_SATADD:  op = OP_SATADD;
      `XIF_F3_RORI: begin
        op   = OP_RORI;
        is_r = 1'b0;
      end
      `XIF_F3_SATADDI: begin
        op   = OP_SATADDI;
        is_r = 1'b0;
      end
      default: known = 1'b0;
    endcase
  end

  // I-type has its immediate where funct7 would be
  assign opnd_ok = is_r ? (ins.r.funct7 == 7'd0) && (x_issue_req_i.rs_valid[1:0] == 2'b11)
                        : x_issue_req_i.rs_valid[0];
  assign accept  = (ins.r.opcode == `XIF_OPC_CUSTOM0) && known && opnd_ok;
  assign wb      = accept && (ins.r.rd != '0);

  assign x_issue_resp_o.accept    = accept;
  assign x_issue_resp_o.writeback = wb;
  assign x_issue_resp_o.dualwrite = 1'b0;
  assign x_issue_resp_o.dualread  = 3'b000;
  assign x_issue_resp_o.loadstore = 1'b0;
  assign x_issue_resp_o.ecswrite  = 1'b0;
  assign x_issue_resp_o.exc       = 1'b0;

  assign uop_o.id        = x_issue_req_i.id;
  assign uop_o.op        = op;
  assign uop_o.rs1       = x_issue_req_i.rs[0];
  assign uop_o.rs2       = x_issue_req_i.rs[1];
  assign uop_o.imm12     = ins.i.imm12;
  assign uop_o.rd        = ins.r.rd;
  assign uop_o.writeback = wb;

  assign uop_accept_o = x_issue_valid_i && accept;

endmodule

//--- coproc/coproc_execute.sv
// Holds accepted instructions in issue order until their commit
// Commits arrive in issue order; only the oldest slot executes or is dropped
// Issue ready is registered, so it is low during reset and for one cycle after
`include "xif_consts.svh"

module coproc_execute (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                uop_accept_i,
  input  xif_pkg::copro_uop_t uop_i,
  input  logic                x_issue_valid_i,
  output logic                x_issue_ready_o,
  input  logic                x_commit_valid_i,
  input  xif_pkg::x_commit_t  x_commit_i,
  input  logic                res_full_i,
  output logic                res_valid_o,
  output xif_pkg::x_result_t  res_o
);
  import xif_pkg::*;

  localparam int SLOTS = `XIF_EXE_SLOTS;
  localparam int CNT_W = $clog2(SLOTS + 1);
  localparam int IDX_W = $clog2(SLOTS);
  localparam logic [`XIF_XLEN-1:0] SMAX = {1'b0, {(`XIF_XLEN-1){1'b1}}};
  localparam logic [`XIF_XLEN-1:0] SMIN = {1'b1, {(`XIF_XLEN-1){1'b0}}};

  copro_uop_t             slot_q [SLOTS];
  copro_uop_t             slot_n [SLOTS];
  copro_uop_t             head;
  logic [SLOTS-1:0]       cmt_q, cmt_n;
  logic [SLOTS-1:0]       kill_q, kill_n;
  logic [CNT_W-1:0]       cnt_q, cnt_n, wr_cnt;
  logic [IDX_W-1:0]       tgt;
  logic                   rdy_q;
  logic                   push, pop;
  logic                   head_cmt, head_kill;
  logic [2*`XIF_XLEN-1:0] rot;
  logic [`XIF_XLEN-1:0]   imm_sx;
  logic [`XIF_XLEN-1:0]   data;

  function automatic logic [`XIF_XLEN-1:0] sat_add(input logic [`XIF_XLEN-1:0] a,
                                                   input logic [`XIF_XLEN-1:0] b);
    logic [`XIF_XLEN:0] sum;
    sum = {a[`XIF_XLEN-1], a} + {b[`XIF_XLEN-1], b};
    if (sum[`XIF_XLEN] != sum[`XIF_XLEN-1]) begin
      return sum[`XIF_XLEN] ? SMIN : SMAX;
    end
    return sum[`XIF_XLEN-1:0];
  endfunction

  // Oldest slot that has not seen its commit yet
  always_comb begin
    tgt = '0;
    for (int i = SLOTS - 1; i >= 0; i--) begin
      if (!cmt_q[i]) tgt = IDX_W'(i);
    end
  end

  assign head      = slot_q[0];
  assign head_cmt  = cmt_q[0] || (x_commit_valid_i && (tgt == '0));
  assign head_kill = cmt_q[0] ? kill_q[0] : x_commit_i.commit_kill;
  // A killed head leaves even when the result queue is full
  assign pop  = (cnt_q != '0) && head_cmt && (head_kill || !res_full_i);
  assign push = x_issue_valid_i && uop_accept_i && rdy_q;

  assign x_issue_ready_o = rdy_q;

  always_comb begin
    rot    = {head.rs1, head.rs1} >> head.imm12[4:0];
    imm_sx = {{(`XIF_XLEN-12){head.imm12[11]}}, head.imm12};
    case (head.op)
      OP_ABSDIFF: data = (head.rs1 > head.rs2) ? head.rs1 - head.rs2 : head.rs2 - head.rs1;
      OP_MINU:    data = (head.rs1 < head.rs2) ? head.rs1 : head.rs2;
      OP_MAXU:    data = (head.rs1 > head.rs2) ? head.rs1 : head.rs2;
      OP_SATADD:  data = sat_add(head.rs1, head.rs2);
      OP_RORI:    data = rot[`XIF_XLEN-1:0];
      default:    data = sat_add(head.rs1, imm_sx);
    endcase
  end

  assign res_valid_o = pop && !head_kill;
  assign res_o.id    = head.id;
  assign res_o.data  = data;
  assign res_o.rd    = head.rd;
  assign res_o.we    = head.writeback;

  always_comb begin
    slot_n = slot_q;
    cmt_n  = cmt_q;
    kill_n = kill_q;
    if (x_commit_valid_i) begin
      cmt_n[tgt]  = 1'b1;
      kill_n[tgt] = x_commit_i.commit_kill;
    end
    // Shift toward the head so slot 0 stays the oldest
    if (pop) begin
      for (int i = 0; i < SLOTS - 1; i++) begin
        slot_n[i] = slot_n[i+1];
      end
      cmt_n  = cmt_n >> 1;
      kill_n = kill_n >> 1;
    end
    wr_cnt = cnt_q - CNT_W'(pop);
    if (push) begin
      slot_n[wr_cnt[IDX_W-1:0]] = uop_i;
      cmt_n[wr_cnt[IDX_W-1:0]]  = 1'b0;
      kill_n[wr_cnt[IDX_W-1:0]] = 1'b0;
    end
    cnt_n = cnt_q + CNT_W'(push) - CNT_W'(pop);
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q  <= '0;
      cmt_q  <= '0;
      kill_q <= '0;
      rdy_q  <= 1'b0;
    end else begin
      cnt_q  <= cnt_n;
      cmt_q  <= cmt_n;
      kill_q <= kill_n;
      rdy_q  <= (cnt_n < CNT_W'(SLOTS));
    end
  end

  always_ff @(posedge clk_i) begin
    slot_q <= slot_n;
  end

  // The adapter only forwards commits for accepted ids, so they must line up
  a_commit_oldest: assert property (@(posedge clk_i) disable iff (rst_i)
    x_commit_valid_i |-> (CNT_W'(tgt) < cnt_q) && (slot_q[tgt].id == x_commit_i.id));

endmodule

//--- coproc/coproc_result.sv
// Two-entry result queue toward the core
// Valid follows occupancy; the writer must not push while full is high
module coproc_result (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               res_valid_i,
  input  xif_pkg::x_result_t res_i,
  output logic               res_full_o,
  output logic               x_result_valid_o,
  input  logic               x_result_ready_i,
  output xif_pkg::x_result_t x_result_o
);
  import xif_pkg::*;

  localparam int DEPTH = 2;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  x_result_t        mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             push, pop;

  assign push             = res_valid_i;
  assign pop              = x_result_valid_o && x_result_ready_i;
  assign res_full_o       = (cnt_q == CNT_W'(DEPTH));
  assign x_result_valid_o = (cnt_q != '0);
  assign x_result_o       = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= res_i;
    end
  end

  // Execute must hold committed work back while the queue is full
  a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
    res_valid_i |-> !res_full_o);

  a_stall_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    x_result_valid_o && !x_result_ready_i |=> x_result_valid_o && $stable(x_result_o));

endmodule

//--- logic/xif_subsys_top.sv
// Adapter plus integer coprocessor, seen from the core as the older protocol
// Only custom-0 instructions are accepted; everything else is rejected at issue
module xif_subsys_top (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      core_issue_valid_i,
  output logic                      core_issue_ready_o,
  input  xif_pkg::core_issue_req_t  core_issue_req_i,
  output xif_pkg::core_issue_resp_t core_issue_resp_o,
  input  logic                      core_commit_valid_i,
  input  xif_pkg::core_commit_t     core_commit_i,
  output logic                      core_result_valid_o,
  input  logic                      core_result_ready_i,
  output xif_pkg::core_result_t     core_result_o
);
  import xif_pkg::*;

  // Coprocessor-side protocol
  logic          x_issue_valid;
  logic          x_issue_ready;
  x_issue_req_t  x_issue_req;
  x_issue_resp_t x_issue_resp;
  logic          x_commit_valid;
  x_commit_t     x_commit;
  logic          x_result_valid;
  logic          x_result_ready;
  x_result_t     x_result;

  // Inside the coprocessor
  copro_uop_t    uop;
  logic          uop_accept;
  logic          res_valid;
  x_result_t     res;
  logic          res_full;

  xif_adapter i_xif_adapter (
    .clk_i               (clk_i),
    .rst_i               (rst_i),
    .core_issue_valid_i  (core_issue_valid_i),
    .core_issue_ready_o  (core_issue_ready_o),
    .core_issue_req_i    (core_issue_req_i),
    .core_issue_resp_o   (core_issue_resp_o),
    .core_commit_valid_i (core_commit_valid_i),
    .core_commit_i       (core_commit_i),
    .core_result_valid_o (core_result_valid_o),
    .core_result_ready_i (core_result_ready_i),
    .core_result_o       (core_result_o),
    .x_issue_valid_o     (x_issue_valid),
    .x_issue_ready_i     (x_issue_ready),
    .x_issue_req_o       (x_issue_req),
    .x_issue_resp_i      (x_issue_resp),
    .x_commit_valid_o    (x_commit_valid),
    .x_commit_o          (x_commit),
    .x_result_valid_i    (x_result_valid),
    .x_result_ready_o    (x_result_ready),
    .x_result_i          (x_result)
  );

  coproc_decode i_coproc_decode (
    .x_issue_valid_i (x_issue_valid),
    .x_issue_req_i   (x_issue_req),
    .x_issue_resp_o  (x_issue_resp),
    .uop_o           (uop),
    .uop_accept_o    (uop_accept)
  );

  coproc_execute i_coproc_execute (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .uop_accept_i     (uop_accept),
    .uop_i            (uop),
    .x_issue_valid_i  (x_issue_valid),
    .x_issue_ready_o  (x_issue_ready),
    .x_commit_valid_i (x_commit_valid),
    .x_commit_i       (x_commit),
    .res_full_i       (res_full),
    .res_valid_o      (res_valid),
    .res_o            (res)
  );

  coproc_result i_coproc_result (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .res_valid_i      (res_valid),
    .res_i            (res),
    .res_full_o       (res_full),
    .x_result_valid_o (x_result_valid),
    .x_result_ready_i (x_result_ready),
    .x_result_o       (x_result)
  );

endmodule

//--- tests/tb_xif_subsys.sv
// Plays the scalar core on the older protocol and commits every issued id in order
// At most four ids are in flight, so the 4-bit id counter may wrap safely
// Expected results are queued at commit and compared in order at each transfer
`include "xif_consts.svh"

module tb_xif_subsys;
  timeunit 1ns;
  timeprecision 1ps;
  import xif_pkg::*;

  // Issue and commit pairs over all test sequences
  localparam int N_TRANS = 35;

  typedef struct packed {
    logic         acc;
    core_result_t res;
  } pend_t;

  logic             clk;
  logic             rst;
  logic             issue_valid;
  logic             issue_ready;
  core_issue_req_t  issue_req;
  core_issue_resp_t issue_resp;
  logic             commit_valid;
  core_commit_t     commit;
  logic             result_valid;
  logic             result_ready;
  core_result_t     result;

  // Reference model
  pend_t                pend_q[$];
  core_result_t         exp_q[$];
  core_result_t         exp_head;
  core_issue_resp_t     exp_resp;
  int                   exp_cnt = 0;
  int                   popped = 0;
  logic                 took = 1'b0;
  logic                 expect_busy;
  logic [`XIF_ID_W-1:0] next_id;
  string                test_name;

  xif_subsys_top i_xif_subsys_top (
    .clk_i               (clk),
    .rst_i               (rst),
    .core_issue_valid_i  (issue_valid),
    .core_issue_ready_o  (issue_ready),
    .core_issue_req_i    (issue_req),
    .core_issue_resp_o   (issue_resp),
    .core_commit_valid_i (commit_valid),
    .core_commit_i       (commit),
    .core_result_valid_o (result_valid),
    .core_result_ready_i (result_ready),
    .core_result_o       (result)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  initial begin
    repeat (N_TRANS * 40) @(posedge clk);
    stop_on_error("Watchdog expired before the tests finished");
  end

  // Model catches up on the falling edge after each transfer
  always @(negedge clk) begin
    if (took) begin
      popped++;
    end
    exp_cnt  = exp_q.size() - popped;
    exp_head = (exp_cnt > 0) ? exp_q[popped] : '0;
    took     = !rst && result_valid && result_ready;
  end

  a_reset_low: assert property (@(posedge clk) rst |=> !issue_ready && !result_valid)
    else stop_on_error("Issue ready or result valid was high after reset");

  a_issue_resp: assert property (@(posedge clk) disable iff (rst)
    issue_valid && issue_ready |-> issue_resp == exp_resp)
    else stop_on_error($sformatf("Error in %s: issue response expected %b actual %b",
                                 test_name, $sampled(exp_resp), $sampled(issue_resp)));

  a_result_expected: assert property (@(posedge clk) disable iff (rst)
    result_valid && result_ready |-> exp_cnt > 0)
    else stop_on_error($sformatf("In %s a result came out while none was due", test_name));

  a_result_value: assert property (@(posedge clk) disable iff (rst)
    result_valid && result_ready |-> result == exp_head)
    else stop_on_error($sformatf("Error in %s: result expected %h actual %h",
                                 test_name, $sampled(exp_head), $sampled(result)));

  a_result_stable: assert property (@(posedge clk) disable iff (rst)
    result_valid && !result_ready |=> result_valid && $stable(result))
    else stop_on_error($sformatf("In %s a stalled result changed or vanished", test_name));

  a_slots_full: assert property (@(posedge clk) disable iff (rst) expect_busy |-> !issue_ready)
    else stop_on_error($sformatf("Error in %s: issue ready expected 0 actual 1", test_name));

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  function automatic logic [31:0] encode_r(input logic [6:0] opc, input logic [6:0] f7,
                                           input logic [2:0] f3, input logic [4:0] rd);
    return {f7, 5'd2, 5'd1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] encode_i(input logic [2:0] f3, input logic [11:0] imm,
                                           input logic [4:0] rd);
    return {imm, 5'd1, f3, rd, `XIF_OPC_CUSTOM0};
  endfunction

  function automatic logic [31:0] expected_data(input logic [2:0] f3, input logic [31:0] a,
                                                input logic [31:0] b, input logic [11:0] imm);
    longint      sum;
    logic [31:0] r;
    r = a;
    case (f3)
      `XIF_F3_ABSDIFF: r = (a >= b) ? a - b : b - a;
      `XIF_F3_MINU:    r = (a < b) ? a : b;
      `XIF_F3_MAXU:    r = (a < b) ? b : a;
      `XIF_F3_RORI: begin
        for (int k = 0; k < int'(imm[4:0]); k++) begin
          r = {r[0], r[31:1]};
        end
      end
      default: begin
        // Register form adds rs2, immediate form the sign-extended imm12
        if (f3 == `XIF_F3_SATADD) sum = longint'($signed(a)) + longint'($signed(b));
        else sum = longint'($signed(a)) + longint'($signed(imm));
        if (sum > 64'sd2147483647) r = 32'h7fff_ffff;
        else if (sum < -64'sd2147483648) r = 32'h8000_0000;
        else r = sum[31:0];
      end
    endcase
    return r;
  endfunction

  task automatic issue_instr(input logic [31:0] instr, input logic [31:0] a,
                             input logic [31:0] b, input logic [1:0] rsv);
    instr_u iw;
    pend_t  p;
    logic   ok;
    iw = instr;
    // R-type needs funct7 zero and both operands, I-type only rs1
    ok = (iw.r.funct3 < `XIF_F3_RORI) ? (iw.r.funct7 == 7'd0) && (rsv == 2'b11) : rsv[0];
    p.acc      = (iw.r.opcode == `XIF_OPC_CUSTOM0) && (iw.r.funct3 <= `XIF_F3_SATADDI) && ok;
    p.res.id   = next_id;
    p.res.rd   = iw.r.rd;
    p.res.we   = p.acc && (iw.r.rd != 5'd0);
    p.res.data = expected_data(iw.r.funct3, a, b, iw.i.imm12);
    exp_resp.accept        = p.acc;
    exp_resp.writeback     = p.res.we;
    exp_resp.register_read = 2'b11;
    issue_req.id       = next_id;
    issue_req.instr    = instr;
    issue_req.rs       = {b, a};
    issue_req.rs_valid = rsv;
    issue_valid        = 1'b1;
    while (!issue_ready) begin
      next_cycle();
    end
    next_cycle();
    issue_valid = 1'b0;
    pend_q.push_back(p);
    next_id = next_id + 1'b1;
  endtask

  task automatic commit_next(input logic kill);
    pend_t p;
    p = pend_q.pop_front();
    commit.id          = p.res.id;
    commit.commit_kill = kill;
    commit_valid       = 1'b1;
    if (p.acc && !kill) begin
      exp_q.push_back(p.res);
    end
    next_cycle();
    commit_valid = 1'b0;
  endtask

  task automatic issue_commit(input logic [31:0] instr, input logic [31:0] a,
                              input logic [31:0] b, input logic [1:0] rsv);
    issue_instr(instr, a, b, rsv);
    commit_next(1'b0);
  endtask

  task automatic wait_drain();
    for (int n = 0; n < 40 && exp_cnt != 0; n++) begin
      next_cycle();
    end
  endtask

  task automatic decode_cases();
    test_name = "decode";
    issue_commit(encode_r(`XIF_OPC_CUSTOM0, 7'd0, `XIF_F3_ABSDIFF, 5'd5), 32'd9, 32'd20, 2'b11);
    issue_commit(encode_r(`XIF_OPC_CUSTOM0, 7'd0, `XIF_F3_MINU, 5'd0), 32'd3, 32'd7, 2'b11);
    // Custom-1 opcode, nonzero funct7, unknown funct3, missing rs2
    issue_commit(encode_r(7'b0101011, 7'd0, `XIF_F3_MAXU, 5'd6), 32'd1, 32'd2, 2'b11);
    issue_commit(encode_r(`XIF_OPC_CUSTOM0, 7'd1, `XIF_F3_MAXU, 5'd6), 32'd1, 32'd2, 2'b11);
    issue_commit(encode_r(`XIF_OPC_CUSTOM0, 7'd0, 3'd6, 5'd6), 32'd1, 32'd2, 2'b11);
    issue_commit(encode_r(`XIF_OPC_CUSTOM0, 7'd0, `XIF_F3_SATADD, 5'd7), 32'd1, 32'd2, 2'b01);
    issue_commit(encode_i(`XIF_F3_RORI, 12'd4, 5'd8), 32'h1234_5678, 32'd0, 2'b01);
    wait_drain();
  endtask

  task automatic operation_sweep();
    logic [31:0] a;
    logic [31:0] b;
    logic [11:0] imm;
    logic [4:0]  rd;
    logic [2:0]  f3;
    test_name = "results";
    // Saturation at both limits, rotation by 0 and 31
    issue_commit(encode_r(`XIF_OPC_CUSTOM0, 7'd0, `XIF_F3_SATADD, 5'd1),
                 32'h7fff_ffff, 32'd1, 2'b11);
    issue_commit(encode_r(`XIF_OPC_CUSTOM0, 7'd0, `XIF_F3_SATADD, 5'd2),
                 32'h8000_0000, 32'hffff_ffff, 2'b11);
    issue_commit(encode_i(`XIF_F3_SATADDI, 12'h7ff, 5'd3), 32'h7fff_fff0, 32'd0, 2'b01);
    issue_commit(encode_i(`XIF_F3_SATADDI, 12'h800, 5'd4), 32'h8000_0005, 32'd0, 2'b01);
    issue_commit(encode_i(`XIF_F3_RORI, 12'h020, 5'd5), 32'hdead_beef, 32'd0, 2'b01);
    issue_commit(encode_i(`XIF_F3_RORI, 12'h01f, 5'd6), 32'hdead_beef, 32'd0, 2'b01);
    for (int k = 0; k < 12; k++) begin
      f3  = 3'(k / 2);
      a   = $urandom();
      b   = $urandom();
      imm = 12'($urandom());
      rd  = 5'($urandom());
      if (f3 < `XIF_F3_RORI) begin
        issue_commit(encode_r(`XIF_OPC_CUSTOM0, 7'd0, f3, rd), a, b, 2'b11);
      end else begin
        issue_commit(encode_i(f3, imm, rd), a, b, 2'b01);
      end
    end
    wait_drain();
  endtask

  task automatic kill_sequence();
    test_name = "kill";
    issue_instr(encode_r(`XIF_OPC_CUSTOM0, 7'd0, `XIF_F3_ABSDIFF, 5'd9),
                $urandom(), $urandom(), 2'b11);
    commit_next(1'b1);
    issue_commit(encode_r(`XIF_OPC_CUSTOM0, 7'd0, `XIF_F3_MINU, 5'd10),
                 $urandom(), $urandom(), 2'b11);
    // Both slots held with the older one killed
    issue_instr(encode_r(`XIF_OPC_CUSTOM0, 7'd0, `XIF_F3_MAXU, 5'd11),
                $urandom(), $urandom(), 2'b11);
    issue_instr(encode_i(`XIF_F3_SATADDI, 12'h123, 5'd12), $urandom(), 32'd0, 2'b01);
    commit_next(1'b1);
    commit_next(1'b0);
    wait_drain();
  endtask

  task automatic stall_results();
    test_name    = "backpressure";
    result_ready = 1'b0;
    // Two results fill the queue and two more wait in execute
    repeat (4) begin
      issue_commit(encode_r(`XIF_OPC_CUSTOM0, 7'd0, `XIF_F3_SATADD, 5'($urandom())),
                   $urandom(), $urandom(), 2'b11);
    end
    repeat (6) next_cycle();
    result_ready = 1'b1;
    wait_drain();
  endtask

  task automatic fill_slots();
    test_name = "full_slots";
    issue_instr(encode_r(`XIF_OPC_CUSTOM0, 7'd0, `XIF_F3_MAXU, 5'd13),
                $urandom(), $urandom(), 2'b11);
    issue_instr(encode_i(`XIF_F3_RORI, 12'd7, 5'd14), $urandom(), 32'd0, 2'b01);
    expect_busy = 1'b1;
    repeat (4) next_cycle();
    expect_busy = 1'b0;
    commit_next(1'b0);
    while (!issue_ready) begin
      next_cycle();
    end
    commit_next(1'b0);
    wait_drain();
  endtask

  initial begin
    void'($urandom(32'h3af6));
    rst          = 1'b1;
    issue_valid  = 1'b0;
    issue_req    = '0;
    commit_valid = 1'b0;
    commit       = '0;
    result_ready = 1'b1;
    exp_resp     = '0;
    expect_busy  = 1'b0;
    next_id      = '0;
    test_name    = "reset";
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    decode_cases();
    operation_sweep();
    kill_sequence();
    stall_results();
    fill_slots();
    wait_drain();
    if (exp_cnt != 0 || pend_q.size() != 0) begin
      stop_on_error($sformatf("%0d expected results never came out", exp_cnt));
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

//--- build.f
+incdir+common
common/xif_pkg.sv
logic/xif_adapter.sv
coproc/coproc_decode.sv
coproc/coproc_execute.sv
coproc/coproc_result.sv
logic/xif_subsys_top.sv
tests/tb_xif_subsys.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= tb_xif_subsys
FILELIST  ?= build.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
